// File: common/cpu_isa_pkg.sv
package cpu_isa_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_idx_t;

  // bit positions inside the instruction word
  localparam int RX_LSB    = 5;
  localparam int RY_LSB    = 8;
  localparam int IMM8_LSB  = 8;
  localparam int IMM11_LSB = 5;

  // one code per instruction pair, bit 4 picks the immediate form
  typedef enum logic [3:0] {
    OP_MV   = 4'b0000,
    OP_ADD  = 4'b0001,
    OP_SUB  = 4'b0010,
    OP_CMP  = 4'b0011,
    OP_LD   = 4'b0100,
    OP_ST   = 4'b0101,
    OP_MVHI = 4'b0110,
    OP_JR   = 4'b1000,
    OP_JZ   = 4'b1001,
    OP_JN   = 4'b1010,
    OP_CALL = 4'b1100
  } opcode_e;

  typedef struct packed {
    logic    imm;
    opcode_e op;
  } ir_op_t;

  typedef enum logic [1:0] {
    PC_RY   = 2'd0,
    PC_NEXT = 2'd1,
    PC_REL  = 2'd2
  } pc_sel_e;

  typedef enum logic [2:0] {
    RF_IMM8 = 3'd0,
    RF_MVHI = 3'd1,
    RF_ALU  = 3'd2,
    RF_RET  = 3'd3,
    RF_MEM  = 3'd4,
    RF_RY   = 3'd5
  } rf_sel_e;

  typedef enum logic {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } alu_op_e;

  typedef struct packed {
    pc_sel_e pc_sel;
    logic    pc_ld;
    logic    ir_ld;
    rf_sel_e rf_sel;
    logic    rf_write;
    logic    rf_w_r7;
    logic    alu_b_ry;
    alu_op_e alu_op;
    logic    flags_ld;
    logic    mem_addr_ry;
  } cpu_ctrl_t;

  typedef struct packed {
    logic n;
    logic z;
  } cpu_flags_t;

endpackage

// File: common/cpu_bus_pkg.sv
package cpu_bus_pkg;

  // core to memory, held steady while waitreq is high
  typedef struct packed {
    logic        rd;
    logic        wr;
    logic [15:0] addr;
    logic [15:0] wrdata;
  } mem_req_t;

  // memory to core, one rddatavalid pulse per accepted read
  typedef struct packed {
    logic        waitreq;
    logic        rddatavalid;
    logic [15:0] rddata;
  } mem_rsp_t;

endpackage

// File: cpu_core/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
  input  logic                    i_clk,
  input  logic                    i_reset,

  input  logic                    i_mem_wait,
  input  logic                    i_mem_rddatavalid,

  input  cpu_isa_pkg::ir_op_t     i_ir,
  input  cpu_isa_pkg::cpu_flags_t i_flags,

  output logic                    o_mem_rd,
  output logic                    o_mem_wr,
  output cpu_isa_pkg::cpu_ctrl_t  o_ctrl
);

  typedef enum logic [1:0] {
    S_FETCH,
    S_LD_IR,
    S_EXECUTE,
    S_MEM_LD
  } state_e;

  state_e state;
  state_e state_nxt;

  // register or relative target, shared by all jumps and calls
  cpu_isa_pkg::pc_sel_e jump_sel;

  assign jump_sel = i_ir.imm ? cpu_isa_pkg::PC_REL : cpu_isa_pkg::PC_RY;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      state <= S_FETCH;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;

    o_mem_rd = 1'b0;
    o_mem_wr = 1'b0;

    o_ctrl.pc_sel      = cpu_isa_pkg::PC_NEXT;
    o_ctrl.pc_ld       = 1'b0;
    o_ctrl.ir_ld       = 1'b0;
    o_ctrl.rf_sel      = cpu_isa_pkg::RF_ALU;
    o_ctrl.rf_write    = 1'b0;
    o_ctrl.rf_w_r7     = 1'b0;
    o_ctrl.alu_b_ry    = 1'b0;
    o_ctrl.alu_op      = cpu_isa_pkg::ALU_ADD;
    o_ctrl.flags_ld    = 1'b0;
    o_ctrl.mem_addr_ry = 1'b0;

    case (state)
      S_FETCH: begin
        // address is the pc
        o_mem_rd = 1'b1;
        if (!i_mem_wait) begin
          state_nxt = S_LD_IR;
        end
      end

      S_LD_IR: begin
        if (i_mem_rddatavalid) begin
          o_ctrl.ir_ld = 1'b1;
          state_nxt    = S_EXECUTE;
        end
      end

      S_EXECUTE: begin
        state_nxt    = S_FETCH;
        o_ctrl.pc_ld = 1'b1;

        case (i_ir.op)
          cpu_isa_pkg::OP_MV: begin
            o_ctrl.rf_write = 1'b1;
            o_ctrl.rf_sel   = i_ir.imm ? cpu_isa_pkg::RF_IMM8 : cpu_isa_pkg::RF_RY;
          end

          cpu_isa_pkg::OP_ADD: begin
            o_ctrl.rf_write = 1'b1;
            o_ctrl.rf_sel   = cpu_isa_pkg::RF_ALU;
            o_ctrl.alu_op   = cpu_isa_pkg::ALU_ADD;
            o_ctrl.alu_b_ry = !i_ir.imm;
            o_ctrl.flags_ld = 1'b1;
          end

          cpu_isa_pkg::OP_SUB: begin
            o_ctrl.rf_write = 1'b1;
            o_ctrl.rf_sel   = cpu_isa_pkg::RF_ALU;
            o_ctrl.alu_op   = cpu_isa_pkg::ALU_SUB;
            o_ctrl.alu_b_ry = !i_ir.imm;
            o_ctrl.flags_ld = 1'b1;
          end

          // subtract for flags only
          cpu_isa_pkg::OP_CMP: begin
            o_ctrl.alu_op   = cpu_isa_pkg::ALU_SUB;
            o_ctrl.alu_b_ry = !i_ir.imm;
            o_ctrl.flags_ld = 1'b1;
          end

          cpu_isa_pkg::OP_LD: begin
            o_mem_rd           = 1'b1;
            o_ctrl.mem_addr_ry = 1'b1;
            o_ctrl.pc_ld       = !i_mem_wait;
            state_nxt          = i_mem_wait ? S_EXECUTE : S_MEM_LD;
          end

          cpu_isa_pkg::OP_ST: begin
            o_mem_wr           = 1'b1;
            o_ctrl.mem_addr_ry = 1'b1;
            o_ctrl.pc_ld       = !i_mem_wait;
            state_nxt          = i_mem_wait ? S_EXECUTE : S_FETCH;
          end

          cpu_isa_pkg::OP_MVHI: begin
            o_ctrl.rf_write = 1'b1;
            o_ctrl.rf_sel   = cpu_isa_pkg::RF_MVHI;
          end

          cpu_isa_pkg::OP_JR: begin
            o_ctrl.pc_sel = jump_sel;
          end

          // not taken falls through to pc + 2
          cpu_isa_pkg::OP_JZ: begin
            if (i_flags.z) begin
              o_ctrl.pc_sel = jump_sel;
            end
          end

          cpu_isa_pkg::OP_JN: begin
            if (i_flags.n) begin
              o_ctrl.pc_sel = jump_sel;
            end
          end

          // return address goes to r7
          cpu_isa_pkg::OP_CALL: begin
            o_ctrl.pc_sel   = jump_sel;
            o_ctrl.rf_write = 1'b1;
            o_ctrl.rf_sel   = cpu_isa_pkg::RF_RET;
            o_ctrl.rf_w_r7  = 1'b1;
          end

          // undefined opcodes just step over
          default: begin
            o_ctrl.pc_sel = cpu_isa_pkg::PC_NEXT;
          end
        endcase
      end

      S_MEM_LD: begin
        if (i_mem_rddatavalid) begin
          o_ctrl.rf_write = 1'b1;
          o_ctrl.rf_sel   = cpu_isa_pkg::RF_MEM;
          state_nxt       = S_FETCH;
        end
      end

      default: begin
        state_nxt = S_FETCH;
      end
    endcase
  end

endmodule

// File: cpu_core/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath #(
  parameter cpu_isa_pkg::word_t RESET_PC = 16'h0000
) (
  input  logic                    i_clk,
  input  logic                    i_reset,

  input  cpu_isa_pkg::cpu_ctrl_t  i_ctrl,
  input  cpu_isa_pkg::word_t      i_mem_rddata,

  output cpu_isa_pkg::ir_op_t     o_ir,
  output cpu_isa_pkg::cpu_flags_t o_flags,
  output cpu_isa_pkg::word_t      o_mem_addr,
  output cpu_isa_pkg::word_t      o_mem_wrdata
);

  cpu_isa_pkg::word_t      pc;
  cpu_isa_pkg::word_t      ir;
  cpu_isa_pkg::word_t      regs [8];
  cpu_isa_pkg::cpu_flags_t flags;

  cpu_isa_pkg::reg_idx_t   rx_idx;
  cpu_isa_pkg::reg_idx_t   ry_idx;
  cpu_isa_pkg::reg_idx_t   rw_idx;
  cpu_isa_pkg::word_t      rx_val;
  cpu_isa_pkg::word_t      ry_val;
  cpu_isa_pkg::word_t      imm8_sx;
  cpu_isa_pkg::word_t      imm11_off;
  cpu_isa_pkg::word_t      pc_plus2;
  cpu_isa_pkg::word_t      pc_nxt;
  cpu_isa_pkg::word_t      alu_b;
  cpu_isa_pkg::word_t      alu_res;
  cpu_isa_pkg::word_t      rf_wdata;

  // instruction fields
  assign rx_idx    = ir[cpu_isa_pkg::RX_LSB +: 3];
  assign ry_idx    = ir[cpu_isa_pkg::RY_LSB +: 3];
  assign imm8_sx   = {{8{ir[15]}}, ir[cpu_isa_pkg::IMM8_LSB +: 8]};
  // word offset scaled to bytes
  assign imm11_off = {{4{ir[15]}}, ir[cpu_isa_pkg::IMM11_LSB +: 11], 1'b0};

  assign rx_val = regs[rx_idx];
  assign ry_val = regs[ry_idx];
  assign rw_idx = i_ctrl.rf_w_r7 ? 3'd7 : rx_idx;

  assign pc_plus2 = pc + 16'd2;

  assign alu_b   = i_ctrl.alu_b_ry ? ry_val : imm8_sx;
  assign alu_res = (i_ctrl.alu_op == cpu_isa_pkg::ALU_SUB) ? rx_val - alu_b : rx_val + alu_b;

  always_comb begin
    case (i_ctrl.pc_sel)
      cpu_isa_pkg::PC_RY:  pc_nxt = ry_val;
      cpu_isa_pkg::PC_REL: pc_nxt = pc_plus2 + imm11_off;
      default:             pc_nxt = pc_plus2;
    endcase
  end

  always_comb begin
    case (i_ctrl.rf_sel)
      cpu_isa_pkg::RF_IMM8: rf_wdata = imm8_sx;
      cpu_isa_pkg::RF_MVHI: rf_wdata = {ir[cpu_isa_pkg::IMM8_LSB +: 8], rx_val[7:0]};
      cpu_isa_pkg::RF_RET:  rf_wdata = pc_plus2;
      cpu_isa_pkg::RF_MEM:  rf_wdata = i_mem_rddata;
      cpu_isa_pkg::RF_RY:   rf_wdata = ry_val;
      default:              rf_wdata = alu_res;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      pc <= RESET_PC;
    end else if (i_ctrl.pc_ld) begin
      pc <= pc_nxt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ctrl.ir_ld) begin
      ir <= i_mem_rddata;
    end
  end

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (i_ctrl.rf_write) begin
      regs[rw_idx] <= rf_wdata;
    end
  end

  // n and z from the last add, sub or cmp
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      flags <= '0;
    end else if (i_ctrl.flags_ld) begin
      flags.n <= alu_res[15];
      flags.z <= (alu_res == 16'h0000);
    end
  end

  assign o_ir         = cpu_isa_pkg::ir_op_t'(ir[4:0]);
  assign o_flags      = flags;
  assign o_mem_addr   = i_ctrl.mem_addr_ry ? ry_val : pc;
  assign o_mem_wrdata = rx_val;

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
  parameter logic [15:0] RESET_PC = 16'h0000
) (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  cpu_bus_pkg::mem_rsp_t i_mem_rsp,
  output cpu_bus_pkg::mem_req_t o_mem_req
);

  cpu_isa_pkg::cpu_ctrl_t  ctrl;
  cpu_isa_pkg::ir_op_t     ir_op;
  cpu_isa_pkg::cpu_flags_t flags;

  cpu_control u_control (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_mem_wait        (i_mem_rsp.waitreq),
    .i_mem_rddatavalid (i_mem_rsp.rddatavalid),
    .i_ir              (ir_op),
    .i_flags           (flags),
    .o_mem_rd          (o_mem_req.rd),
    .o_mem_wr          (o_mem_req.wr),
    .o_ctrl            (ctrl)
  );

  cpu_datapath #(
    .RESET_PC (RESET_PC)
  ) u_datapath (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_ctrl       (ctrl),
    .i_mem_rddata (i_mem_rsp.rddata),
    .o_ir         (ir_op),
    .o_flags      (flags),
    .o_mem_addr   (o_mem_req.addr),
    .o_mem_wrdata (o_mem_req.wrdata)
  );

endmodule

// File: verification/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  cpu_bus_pkg::mem_req_t i_mem_req,
  input  cpu_bus_pkg::mem_rsp_t i_mem_rsp,
  input  logic [7:0]            i_exp_test [32],
  input  logic [15:0]           i_exp_addr [32],
  input  logic [15:0]           i_exp_data [32],
  input  int                    i_exp_count,
  output logic                  o_first_seen,
  output int                    o_store_count,
  output int                    o_extra_count,
  output int                    o_error_count
);

  int test_errors;

  function automatic string test_name(input logic [7:0] t);
    case (t)
      8'd2:    return "moves and arithmetic";
      8'd3:    return "compare and branches";
      8'd4:    return "load and store";
      8'd5:    return "call and return";
      default: return "unnamed";
    endcase
  endfunction

  initial begin
    o_first_seen  = 1'b0;
    o_store_count = 0;
    o_extra_count = 0;
    o_error_count = 0;
    test_errors   = 0;
  end

  always @(posedge i_clk) begin
    if (!i_reset && (i_mem_req.rd || i_mem_req.wr) && !i_mem_rsp.waitreq) begin
      // the very first request must be the fetch at the reset pc
      if (!o_first_seen) begin
        o_first_seen = 1'b1;
        if (!i_mem_req.rd || i_mem_req.wr || i_mem_req.addr != 16'h0000) begin
          $display("ERROR o_mem_req first request rd %h wr %h addr %h, expected 1 0 0000",
                   i_mem_req.rd, i_mem_req.wr, i_mem_req.addr);
          o_error_count++;
          $display("test 1 reset: FAILED");
        end else begin
          $display("test 1 reset: ok");
        end
      end

      if (i_mem_req.wr) begin
        if (o_store_count >= i_exp_count) begin
          $display("unexpected extra store of %h to address %h after the last expected one",
                   i_mem_req.wrdata, i_mem_req.addr);
          o_extra_count++;
          o_error_count++;
        end else begin
          if (i_mem_req.addr != i_exp_addr[o_store_count]) begin
            $display("ERROR o_mem_req.addr got %h expected %h",
                     i_mem_req.addr, i_exp_addr[o_store_count]);
            test_errors++;
          end
          if (i_mem_req.wrdata != i_exp_data[o_store_count]) begin
            $display("ERROR o_mem_req.wrdata got %h expected %h",
                     i_mem_req.wrdata, i_exp_data[o_store_count]);
            test_errors++;
          end
          o_store_count++;
          // last store of a test closes it
          if (o_store_count == i_exp_count ||
              i_exp_test[o_store_count] != i_exp_test[o_store_count - 1]) begin
            $display("test %0d %s: %s", i_exp_test[o_store_count - 1],
                     test_name(i_exp_test[o_store_count - 1]),
                     (test_errors == 0) ? "ok" : "FAILED");
            o_error_count += test_errors;
            test_errors = 0;
          end
        end
      end
    end
  end

endmodule

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

  localparam int RESET_CYCLES  = 5;
  localparam int START_TIMEOUT = 50;
  localparam int STORE_TIMEOUT = 600;
  localparam int QUIET_CYCLES  = 300;

  logic                  i_clk;
  logic                  i_reset;
  cpu_bus_pkg::mem_req_t mem_req;
  cpu_bus_pkg::mem_rsp_t mem_rsp;

  // word array indexed by byte address bits [8:1]
  logic [15:0] mem [256];

  logic [7:0]  exp_test [32];
  logic [15:0] exp_addr [32];
  logic [15:0] exp_data [32];
  int          exp_count;

  int          store_count;
  int          extra_count;
  int          error_count;
  logic        first_seen;

  integer      seed;
  logic        rd_pending;
  logic [7:0]  rd_index;
  int          rd_delay;

  cpu_top #(
    .RESET_PC (16'h0000)
  ) uut (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_mem_rsp (mem_rsp),
    .o_mem_req (mem_req)
  );

  cpu_checker u_checker (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_mem_req     (mem_req),
    .i_mem_rsp     (mem_rsp),
    .i_exp_test    (exp_test),
    .i_exp_addr    (exp_addr),
    .i_exp_data    (exp_data),
    .i_exp_count   (exp_count),
    .o_first_seen  (first_seen),
    .o_store_count (store_count),
    .o_extra_count (extra_count),
    .o_error_count (error_count)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // accepted requests are taken on the rising edge
  always @(posedge i_clk) begin
    if (!i_reset && !mem_rsp.waitreq) begin
      if (mem_req.wr) begin
        mem[mem_req.addr[8:1]] = mem_req.wrdata;
      end
      if (mem_req.rd) begin
        rd_pending = 1'b1;
        rd_index   = mem_req.addr[8:1];
        rd_delay   = 1 + int'($unsigned($random(seed)) % 3);
      end
    end
  end

  // bus responses change on the falling edge
  always @(negedge i_clk) begin
    mem_rsp.waitreq     = ($unsigned($random(seed)) % 3) == 0;
    mem_rsp.rddatavalid = 1'b0;
    if (rd_pending) begin
      rd_delay = rd_delay - 1;
      if (rd_delay == 0) begin
        mem_rsp.rddatavalid = 1'b1;
        mem_rsp.rddata      = mem[rd_index];
        rd_pending          = 1'b0;
      end
    end
  end

  task automatic load_vectors(output logic ok);
    int          fd;
    int          code;
    string       tag;
    string       rest;
    logic [15:0] addr;
    logic [15:0] w [4];
    int          t;
    logic [15:0] d;
    ok = 1'b0;
    fd = $fopen("verification/cpu_vectors.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tag);
        if (code != 1) break;
        if (tag == "P") begin
          code = $fscanf(fd, "%h %h %h %h %h", addr, w[0], w[1], w[2], w[3]);
          for (int i = 0; i < 4; i++) begin
            mem[addr[8:1] + 8'(i)] = w[i];
          end
        end else if (tag == "E") begin
          code = $fscanf(fd, "%d %h %h", t, addr, d);
          exp_test[exp_count] = 8'(t);
          exp_addr[exp_count] = addr;
          exp_data[exp_count] = d;
          exp_count++;
        end else begin
          code = $fgets(rest, fd);
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    logic loaded;
    logic hung;
    int   cycles;
    seed       = 32'h1df94994;
    i_reset    = 1'b1;
    mem_rsp    = '0;
    rd_pending = 1'b0;
    rd_index   = '0;
    rd_delay   = 0;
    exp_count  = 0;
    hung       = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i), ~8'(i)};
    end
    for (int i = 0; i < 32; i++) begin
      exp_test[i] = '0;
      exp_addr[i] = '0;
      exp_data[i] = '0;
    end
    load_vectors(loaded);
    if (!loaded) begin
      $display("cannot open verification/cpu_vectors.txt");
    end
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge i_clk);
    end
    i_reset = 1'b0;

    cycles = 0;
    while (!first_seen && cycles < START_TIMEOUT) begin
      @(negedge i_clk);
      cycles++;
    end
    if (!first_seen) begin
      $display("timeout: no bus request was accepted after reset release");
      hung = 1'b1;
    end

    for (int k = 0; k < exp_count && !hung; k++) begin
      cycles = 0;
      while (store_count <= k && cycles < STORE_TIMEOUT) begin
        @(negedge i_clk);
        cycles++;
      end
      if (store_count <= k) begin
        $display("timeout: store %0d of test %0d never reached the bus", k + 1, exp_test[k]);
        hung = 1'b1;
      end
    end

    // the end loop must leave the bus free of writes
    cycles = 0;
    while (!hung && cycles < QUIET_CYCLES) begin
      @(negedge i_clk);
      cycles++;
    end
    $display("test 6 back-pressure: %0d of %0d stores, %0d extra after the end loop: %s",
             store_count, exp_count, extra_count,
             (store_count == exp_count && extra_count == 0 && !hung) ? "ok" : "FAILED");
    $display("summary: %0d stores checked, %0d expected, %0d errors, timeout %0d",
             store_count, exp_count, error_count, hung);

    if (loaded && !hung && error_count == 0 && store_count == exp_count && exp_count > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verification/cpu_vectors.txt
# P addr w0 w1 w2 w3 : memory words at addr, addr+2, addr+4, addr+6 (hex)
# E test addr data : expected stores in bus order (test decimal, rest hex)
P 0000 01D6 0530 FD50 0160
P 0008 0261 0665 02D1 0932
P 0010 0625 02D1 0142 AB56
P 0018 0645 02D1 FC33 0039
P 0020 4091 003A 0191 0509
P 0028 0685 02D1 0033 34B0
P 0030 050A 4091 0039 0291
P 0038 003A 0393 42B0 0509
P 0040 4091 0685 02D1 80B0
P 0048 01B6 0524 02B1 0544
P 0050 0221 0625 0525 0564
P 0058 0472 02D1 0665 02D1
P 0060 00FC 5590 0685 02D1
P 0068 70B0 050C 6690 0078
P 0070 06E5 02D1 0708 0685
P 0078 FFF8 0000 0000 0000
P 0180 1234 0FF0 0000 0000
E 2 0100 0002
E 2 0102 FFFC
E 2 0104 AB01
E 3 0106 0001
E 3 0108 0003
E 4 010A 2224
E 4 0182 2224
E 4 010C 2220
E 5 010E 0062
E 5 0110 0055
E 5 0112 006C
E 5 0114 0066

// File: compile.f
common/cpu_isa_pkg.sv
common/cpu_bus_pkg.sv
cpu_core/cpu_control.sv
cpu_core/cpu_datapath.sv
verilog/cpu_top.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= cpu_tb
RTL_TOP   ?= cpu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST)) verification/cpu_vectors.txt
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
